// ==== include/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ======================================================================
// address map
// ======================================================================

// 1 KiB of word-addressed RAM at the bottom of the map
`define RAM_BASE_ADDR 32'h0000_0000
`define RAM_MASK_ADDR 32'h0000_03FF

// core-local interruptor with a 64 KiB window
`define CLINT_BASE_ADDR 32'h0200_0000
`define CLINT_MASK_ADDR 32'h0000_FFFF

// uart transmitter with data at 0x0 and status at 0x4
`define UART_TX_BASE_ADDR 32'h1000_0000
`define UART_TX_MASK_ADDR 32'h0000_000F

// ======================================================================
// block sizes and rates
// ======================================================================

// number of 32-bit words held by the RAM
`define RAM_DEPTH 256

// main clocks per mtime tick
`define CLINT_PRESCALE 4

// main clocks per serial bit
`define UART_CLOCKS_PER_BIT 8

`endif

// ==== hdl/soc_pkg.sv ====
package soc_pkg;

  // request from the host side of the bus
  // a strobe of zero marks the access as a read
  typedef struct packed {
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
  } mem_in_t;

  // response from a target
  // ready is a single-cycle pulse
  typedef struct packed {
    logic        mem_ready;
    logic        mem_error;
    logic [31:0] mem_rdata;
  } mem_out_t;

  localparam mem_in_t init_mem_in = '{
    mem_valid: 1'b0,
    mem_addr: 32'h0,
    mem_wdata: 32'h0,
    mem_wstrb: 4'h0
  };

  localparam mem_out_t init_mem_out = '{
    mem_ready: 1'b0,
    mem_error: 1'b0,
    mem_rdata: 32'h0
  };

endpackage

// ==== hdl/bus_decoder.sv ====
`timescale 1ns/1ps

`include "soc_config.svh"

module bus_decoder (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_in_t  host_in,
  output soc_pkg::mem_out_t host_out,
  output soc_pkg::mem_in_t  ram_in,
  input  soc_pkg::mem_out_t ram_out,
  output soc_pkg::mem_in_t  clint_in,
  input  soc_pkg::mem_out_t clint_out,
  output soc_pkg::mem_in_t  uart_in,
  input  soc_pkg::mem_out_t uart_out
);

  logic        ram_hit;
  logic        clint_hit;
  logic        uart_hit;
  logic        miss;
  logic [31:0] base_addr;
  logic [31:0] local_addr;

  soc_pkg::mem_out_t error_out;

  // ======================================================================
  // address match
  // ======================================================================

  assign ram_hit   = (host_in.mem_addr & ~`RAM_MASK_ADDR) == `RAM_BASE_ADDR;
  assign clint_hit = (host_in.mem_addr & ~`CLINT_MASK_ADDR) == `CLINT_BASE_ADDR;
  assign uart_hit  = (host_in.mem_addr & ~`UART_TX_MASK_ADDR) == `UART_TX_BASE_ADDR;

  assign miss = host_in.mem_valid & ~(ram_hit | clint_hit | uart_hit);

  always_comb begin
    base_addr = 32'h0;
    if (ram_hit) begin
      base_addr = `RAM_BASE_ADDR;
    end else if (clint_hit) begin
      base_addr = `CLINT_BASE_ADDR;
    end else if (uart_hit) begin
      base_addr = `UART_TX_BASE_ADDR;
    end
  end

  // targets only ever see the offset inside their own window
  assign local_addr = host_in.mem_addr - base_addr;

  // ======================================================================
  // request routing
  // ======================================================================

  always_comb begin
    ram_in   = soc_pkg::init_mem_in;
    clint_in = soc_pkg::init_mem_in;
    uart_in  = soc_pkg::init_mem_in;
    if (host_in.mem_valid == 1'b1) begin
      if (ram_hit) begin
        ram_in          = host_in;
        ram_in.mem_addr = local_addr;
      end else if (clint_hit) begin
        clint_in          = host_in;
        clint_in.mem_addr = local_addr;
      end else if (uart_hit) begin
        uart_in          = host_in;
        uart_in.mem_addr = local_addr;
      end
    end
  end

  // unmapped accesses are answered here, one cycle later like any target
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      error_out <= soc_pkg::init_mem_out;
    end else begin
      error_out.mem_ready <= miss;
      error_out.mem_error <= miss;
      error_out.mem_rdata <= 32'h0;
    end
  end

  // ======================================================================
  // response mux
  // ======================================================================

  // at most one responder pulses ready in any cycle
  always_comb begin
    host_out = soc_pkg::init_mem_out;
    if (ram_out.mem_ready == 1'b1) begin
      host_out = ram_out;
    end else if (clint_out.mem_ready == 1'b1) begin
      host_out = clint_out;
    end else if (uart_out.mem_ready == 1'b1) begin
      host_out = uart_out;
    end else if (error_out.mem_ready == 1'b1) begin
      host_out = error_out;
    end
  end

endmodule

// ==== hdl/ram.sv ====
`timescale 1ns/1ps

`include "soc_config.svh"

module ram (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_in_t  ram_in,
  output soc_pkg::mem_out_t ram_out
);

  localparam int index_bits = $clog2(`RAM_DEPTH);

  logic [31:0]           memory [`RAM_DEPTH];
  logic [index_bits-1:0] index;
  logic                  ready_q;
  logic [31:0]           rdata_q;

  // the word address drops the two byte-offset bits
  assign index = ram_in.mem_addr[index_bits+1:2];

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= ram_in.mem_valid;
    end
  end

  // a write also returns the old word, which the host ignores
  always_ff @(posedge clock) begin
    if (ram_in.mem_valid == 1'b1) begin
      for (int i = 0; i < 4; i++) begin
        if (ram_in.mem_wstrb[i]) begin
          memory[index][8*i +: 8] <= ram_in.mem_wdata[8*i +: 8];
        end
      end
      rdata_q <= memory[index];
    end
  end

  assign ram_out.mem_ready = ready_q;
  assign ram_out.mem_error = 1'b0;
  assign ram_out.mem_rdata = rdata_q;

endmodule

// ==== hdl/clint.sv ====
`timescale 1ns/1ps

`include "soc_config.svh"

module clint #(
  parameter int prescale = `CLINT_PRESCALE
) (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_in_t  clint_in,
  output soc_pkg::mem_out_t clint_out,
  output logic              msip,
  output logic              mtip
);

  localparam int prescale_bits = $clog2(prescale + 1);
  localparam logic [prescale_bits-1:0] prescale_last = prescale_bits'(prescale - 1);

  localparam logic [15:0] msip_offset       = 16'h0000;
  localparam logic [15:0] mtimecmp_lo_offset = 16'h4000;
  localparam logic [15:0] mtimecmp_hi_offset = 16'h4004;
  localparam logic [15:0] mtime_lo_offset    = 16'hBFF8;
  localparam logic [15:0] mtime_hi_offset    = 16'hBFFC;

  logic [prescale_bits-1:0] prescale_count;
  logic                     tick;
  logic [63:0]              mtime;
  logic [63:0]              mtimecmp;
  logic [15:0]              offset;
  logic                     write;
  logic [31:0]              read_value;
  logic                     ready_q;
  logic [31:0]              rdata_q;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_value,
                                              input logic [31:0] new_value,
                                              input logic [3:0] strobe);
    logic [31:0] result;
    result = old_value;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) begin
        result[8*i +: 8] = new_value[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign offset = clint_in.mem_addr[15:0];
  assign write  = clint_in.mem_valid & (|clint_in.mem_wstrb);
  assign tick   = prescale_count == prescale_last;

  // ======================================================================
  // timer, compare and software interrupt
  // ======================================================================

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      prescale_count <= '0;
      mtime          <= 64'h0;
      mtimecmp       <= '1;
      msip           <= 1'b0;
      mtip           <= 1'b0;
      ready_q        <= 1'b0;
    end else begin
      ready_q <= clint_in.mem_valid;
      mtip    <= mtime >= mtimecmp;
      if (tick) begin
        prescale_count <= '0;
        mtime          <= mtime + 64'h1;
      end else begin
        prescale_count <= prescale_count + 1'b1;
      end
      // a bus write to mtime takes priority over the tick
      if (write) begin
        case (offset)
          msip_offset: begin
            if (clint_in.mem_wstrb[0]) begin
              msip <= clint_in.mem_wdata[0];
            end
          end
          mtimecmp_lo_offset: begin
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], clint_in.mem_wdata,
                                          clint_in.mem_wstrb);
          end
          mtimecmp_hi_offset: begin
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], clint_in.mem_wdata,
                                           clint_in.mem_wstrb);
          end
          mtime_lo_offset: begin
            mtime[31:0] <= merge_bytes(mtime[31:0], clint_in.mem_wdata, clint_in.mem_wstrb);
          end
          mtime_hi_offset: begin
            mtime[63:32] <= merge_bytes(mtime[63:32], clint_in.mem_wdata, clint_in.mem_wstrb);
          end
          default: begin
          end
        endcase
      end
    end
  end

  // ======================================================================
  // bus read side
  // ======================================================================

  always_comb begin
    case (offset)
      msip_offset:        read_value = {31'h0, msip};
      mtimecmp_lo_offset: read_value = mtimecmp[31:0];
      mtimecmp_hi_offset: read_value = mtimecmp[63:32];
      mtime_lo_offset:    read_value = mtime[31:0];
      mtime_hi_offset:    read_value = mtime[63:32];
      default:            read_value = 32'h0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (clint_in.mem_valid == 1'b1) begin
      rdata_q <= read_value;
    end
  end

  assign clint_out.mem_ready = ready_q;
  assign clint_out.mem_error = 1'b0;
  assign clint_out.mem_rdata = rdata_q;

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

`include "soc_config.svh"

module uart_tx #(
  parameter int clocks_per_bit = `UART_CLOCKS_PER_BIT
) (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::mem_in_t  uart_in,
  output soc_pkg::mem_out_t uart_out,
  output logic              tx
);

  localparam int count_bits = $clog2(clocks_per_bit + 1);
  localparam logic [count_bits-1:0] last_count = count_bits'(clocks_per_bit - 1);

  localparam logic [3:0] data_offset   = 4'h0;
  localparam logic [3:0] status_offset = 4'h4;

  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } state_t;

  state_t                state;
  logic [count_bits-1:0] count;
  logic [2:0]            bit_index;
  logic [7:0]            shift;
  logic                  busy;
  logic                  bit_done;
  logic                  write;
  logic                  load;
  logic                  refuse;
  logic                  ready_q;
  logic                  error_q;
  logic [31:0]           rdata_q;

  assign busy     = state != idle;
  assign bit_done = count == last_count;
  assign write    = uart_in.mem_valid & (|uart_in.mem_wstrb)
                    & (uart_in.mem_addr[3:0] == data_offset);
  // a byte written while a frame is on the line is dropped
  assign load     = write & ~busy;
  assign refuse   = write & busy;

  // ======================================================================
  // transmit FSM
  // ======================================================================

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state     <= idle;
      count     <= '0;
      bit_index <= 3'h0;
      tx        <= 1'b1;
    end else begin
      case (state)
        idle: begin
          if (load) begin
            state <= start;
            count <= '0;
            tx    <= 1'b0;
          end
        end
        start: begin
          if (bit_done) begin
            state     <= data;
            count     <= '0;
            bit_index <= 3'h0;
            tx        <= shift[0];
          end else begin
            count <= count + 1'b1;
          end
        end
        data: begin
          if (bit_done) begin
            count <= '0;
            if (bit_index == 3'h7) begin
              state <= stop;
              tx    <= 1'b1;
            end else begin
              bit_index <= bit_index + 3'h1;
              tx        <= shift[0];
            end
          end else begin
            count <= count + 1'b1;
          end
        end
        stop: begin
          if (bit_done) begin
            state <= idle;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // lsb goes out first, so the byte shifts right as each data bit starts
  always_ff @(posedge clock) begin
    if (load) begin
      shift <= uart_in.mem_wdata[7:0];
    end else if (bit_done && (state == start || state == data)) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  // ======================================================================
  // bus registers
  // ======================================================================

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= uart_in.mem_valid;
      error_q <= refuse;
    end
  end

  always_ff @(posedge clock) begin
    if (uart_in.mem_valid == 1'b1) begin
      if (uart_in.mem_wstrb == 4'h0 && uart_in.mem_addr[3:0] == status_offset) begin
        rdata_q <= {31'h0, busy};
      end else begin
        rdata_q <= 32'h0;
      end
    end
  end

  assign uart_out.mem_ready = ready_q;
  assign uart_out.mem_error = error_q;
  assign uart_out.mem_rdata = rdata_q;

endmodule

// ==== hdl/soc_bus.sv ====
`timescale 1ns/1ps

module soc_bus (
  input  logic        clock,
  input  logic        reset,
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  output logic [31:0] mem_rdata,
  output logic        mem_ready,
  output logic        mem_error,
  output logic        msip,
  output logic        mtip,
  output logic        tx
);

  soc_pkg::mem_in_t  host_in;
  soc_pkg::mem_out_t host_out;

  soc_pkg::mem_in_t  ram_in;
  soc_pkg::mem_out_t ram_out;
  soc_pkg::mem_in_t  clint_in;
  soc_pkg::mem_out_t clint_out;
  soc_pkg::mem_in_t  uart_in;
  soc_pkg::mem_out_t uart_out;

  // host side of the bus, as seen by the processor
  assign host_in.mem_valid = mem_valid;
  assign host_in.mem_addr  = mem_addr;
  assign host_in.mem_wdata = mem_wdata;
  assign host_in.mem_wstrb = mem_wstrb;

  assign mem_ready = host_out.mem_ready;
  assign mem_error = host_out.mem_error;
  assign mem_rdata = host_out.mem_rdata;

  bus_decoder bus_decoder_i (
    .clock    (clock),
    .reset    (reset),
    .host_in  (host_in),
    .host_out (host_out),
    .ram_in   (ram_in),
    .ram_out  (ram_out),
    .clint_in (clint_in),
    .clint_out(clint_out),
    .uart_in  (uart_in),
    .uart_out (uart_out)
  );

  ram ram_i (
    .clock  (clock),
    .reset  (reset),
    .ram_in (ram_in),
    .ram_out(ram_out)
  );

  clint clint_i (
    .clock    (clock),
    .reset    (reset),
    .clint_in (clint_in),
    .clint_out(clint_out),
    .msip     (msip),
    .mtip     (mtip)
  );

  uart_tx uart_tx_i (
    .clock   (clock),
    .reset   (reset),
    .uart_in (uart_in),
    .uart_out(uart_out),
    .tx      (tx)
  );

endmodule

// ==== verification/soc_bus_tb.sv ====
`timescale 1ns/1ps

`include "soc_config.svh"

module soc_bus_tb;

  localparam int ram_words = 16;
  localparam int uart_frames = 2;
  localparam int mtime_gap = 40;
  localparam int ticks_ahead = 5;
  localparam int frame_cycles = 10 * `UART_CLOCKS_PER_BIT;
  localparam int bus_transactions = 3 * ram_words + 8 + uart_frames * 12 + 12;
  localparam int clint_cycles = mtime_gap + (ticks_ahead + 3) * `CLINT_PRESCALE;
  localparam int watchdog_cycles =
    2 * (4 * bus_transactions + uart_frames * 3 * frame_cycles + clint_cycles) + 20;

  localparam logic [31:0] mtimecmp_lo = `CLINT_BASE_ADDR + 32'h4000;
  localparam logic [31:0] mtimecmp_hi = `CLINT_BASE_ADDR + 32'h4004;
  localparam logic [31:0] mtime_lo = `CLINT_BASE_ADDR + 32'hBFF8;

  logic        clock;
  logic        reset;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        mem_error;
  logic        msip;
  logic        mtip;
  logic        tx;

  logic [31:0] lfsr_state = 32'd19814;
  logic [31:0] ram_model [`RAM_DEPTH];
  int          cycle_count = 0;

  soc_bus soc_bus_i (
    .clock    (clock),
    .reset    (reset),
    .mem_valid(mem_valid),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .mem_error(mem_error),
    .msip     (msip),
    .mtip     (mtip),
    .tx       (tx)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  // ======================================================================
  // helpers and reference models
  // ======================================================================

  task abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH time %0t signal %s actual 0x%h expected 0x%h",
                          $time, name, actual, expected));
    end
  endtask

  // the galois lfsr steps once for every bit handed out
  function automatic logic [31:0] next_bits(input int count);
    logic [31:0] value;
    value = 32'h0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return value;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strobe);
    logic [31:0] word;
    word = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) begin
        word[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return word;
  endfunction

  // bit 0 goes on the line first
  function automatic logic [9:0] uart_frame(input logic [7:0] data);
    return {1'b1, data, 1'b0};
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output logic resp_error);
    int cycles;
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    @(posedge clock);
    #1;
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
    cycles = 1;
    while (mem_ready !== 1'b1 && cycles < 8) begin
      @(posedge clock);
      #1;
      cycles++;
    end
    if (mem_ready !== 1'b1) begin
      abort_run($sformatf("no ready response for the request to address 0x%h", addr));
    end
    check_value("mem_ready latency", 32'(cycles), 32'd1);
    rdata = mem_rdata;
    resp_error = mem_error;
  endtask

  // ======================================================================
  // tests
  // ======================================================================

  task automatic ram_test();
    logic [7:0]  index [ram_words];
    int          order [ram_words];
    logic [31:0] data;
    logic [31:0] rdata;
    logic [3:0]  strobe;
    logic        resp_error;
    int          pick;
    int          swap;
    for (int i = 0; i < ram_words; i++) begin
      index[i] = 8'(next_bits(8));
      data = next_bits(32);
      bus_access({22'h0, index[i], 2'b00}, data, 4'hF, rdata, resp_error);
      ram_model[index[i]] = data;
      check_value("ram write mem_error", 32'(resp_error), 32'h0);
    end
    for (int i = 0; i < ram_words; i++) begin
      data = next_bits(32);
      strobe = 4'(next_bits(4));
      if (strobe == 4'h0) begin
        strobe = 4'h1;
      end
      bus_access({22'h0, index[i], 2'b00}, data, strobe, rdata, resp_error);
      ram_model[index[i]] = expected_word(ram_model[index[i]], data, strobe);
      check_value("ram write mem_error", 32'(resp_error), 32'h0);
    end
    for (int i = 0; i < ram_words; i++) begin
      order[i] = i;
    end
    for (int i = ram_words - 1; i > 0; i--) begin
      pick = int'(next_bits(4)) % (i + 1);
      swap = order[i];
      order[i] = order[pick];
      order[pick] = swap;
    end
    for (int i = 0; i < ram_words; i++) begin
      bus_access({22'h0, index[order[i]], 2'b00}, 32'h0, 4'h0, rdata, resp_error);
      check_value("ram read mem_rdata", rdata, ram_model[index[order[i]]]);
      check_value("ram read mem_error", 32'(resp_error), 32'h0);
    end
  endtask

  task automatic unmapped_test();
    logic [31:0] bad_addr [6];
    logic [31:0] data;
    logic [31:0] rdata;
    logic        resp_error;
    logic [7:0]  index;
    bad_addr[0] = 32'h0000_0400;
    bad_addr[1] = 32'h1000_0010;
    bad_addr[2] = 32'h0201_0000;
    for (int i = 3; i < 6; i++) begin
      bad_addr[i] = next_bits(32) | 32'h8000_0000;
    end
    for (int i = 0; i < 6; i++) begin
      bus_access(bad_addr[i], next_bits(32), 4'(next_bits(4)), rdata, resp_error);
      check_value("unmapped mem_error", 32'(resp_error), 32'h1);
      check_value("unmapped mem_rdata", rdata, 32'h0);
    end
    // the bus must still serve the RAM normally afterwards
    index = 8'(next_bits(8));
    data = next_bits(32);
    bus_access({22'h0, index, 2'b00}, data, 4'hF, rdata, resp_error);
    check_value("ram write mem_error", 32'(resp_error), 32'h0);
    bus_access({22'h0, index, 2'b00}, 32'h0, 4'h0, rdata, resp_error);
    check_value("ram read mem_rdata", rdata, data);
    check_value("ram read mem_error", 32'(resp_error), 32'h0);
  endtask

  task automatic uart_test(input logic [7:0] first, input logic [7:0] second);
    logic [9:0]  frame;
    logic [31:0] rdata;
    logic        resp_error;
    int          polls;
    frame = uart_frame(first);
    bus_access(`UART_TX_BASE_ADDR, {24'h0, first}, 4'hF, rdata, resp_error);
    check_value("uart write mem_error", 32'(resp_error), 32'h0);
    fork
      begin
        repeat (`UART_CLOCKS_PER_BIT / 2) @(posedge clock);
        #1;
        for (int b = 0; b < 10; b++) begin
          check_value($sformatf("tx frame bit %0d", b), 32'(tx), 32'(frame[b]));
          if (b < 9) begin
            repeat (`UART_CLOCKS_PER_BIT) @(posedge clock);
            #1;
          end
        end
      end
      begin
        repeat (2) @(posedge clock);
        #1;
        bus_access(`UART_TX_BASE_ADDR + 32'h4, 32'h0, 4'h0, rdata, resp_error);
        check_value("uart status busy", rdata, 32'h1);
        bus_access(`UART_TX_BASE_ADDR, {24'h0, second}, 4'hF, rdata, resp_error);
        check_value("uart refused write mem_error", 32'(resp_error), 32'h1);
      end
    join
    rdata = 32'h1;
    polls = 0;
    while (rdata[0] == 1'b1 && polls < 4 * `UART_CLOCKS_PER_BIT) begin
      bus_access(`UART_TX_BASE_ADDR + 32'h4, 32'h0, 4'h0, rdata, resp_error);
      polls++;
    end
    if (rdata[0] == 1'b1) begin
      abort_run("uart status stayed busy long after the end of its frame");
    end
    // a dropped byte would show up here as a start bit
    repeat (frame_cycles) begin
      @(posedge clock);
      #1;
      check_value("tx idle after frame", 32'(tx), 32'h1);
    end
  endtask

  task automatic clint_test();
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] rdata;
    logic        resp_error;
    int          delta;
    int          start;
    bus_access(`CLINT_BASE_ADDR, 32'h1, 4'hF, rdata, resp_error);
    check_value("msip", 32'(msip), 32'h1);
    bus_access(`CLINT_BASE_ADDR, 32'h0, 4'hF, rdata, resp_error);
    check_value("msip", 32'(msip), 32'h0);
    bus_access(mtime_lo, 32'h0, 4'h0, first, resp_error);
    repeat (mtime_gap - 1) @(posedge clock);
    #1;
    bus_access(mtime_lo, 32'h0, 4'h0, second, resp_error);
    delta = int'(second - first);
    if (delta < mtime_gap / `CLINT_PRESCALE - 1 || delta > mtime_gap / `CLINT_PRESCALE + 1) begin
      check_value("mtime delta", 32'(delta), 32'(mtime_gap / `CLINT_PRESCALE));
    end
    bus_access(mtime_lo, 32'h0, 4'h0, first, resp_error);
    start = cycle_count;
    bus_access(mtimecmp_lo, first + ticks_ahead, 4'hF, rdata, resp_error);
    bus_access(mtimecmp_hi, 32'h0, 4'hF, rdata, resp_error);
    check_value("mtip before compare", 32'(mtip), 32'h0);
    while (mtip !== 1'b1 && cycle_count - start <= (ticks_ahead + 1) * `CLINT_PRESCALE) begin
      @(posedge clock);
      #1;
    end
    if (mtip !== 1'b1) begin
      abort_run("mtip did not rise within the expected number of timer ticks");
    end
    repeat (2 * `CLINT_PRESCALE) begin
      @(posedge clock);
      #1;
      check_value("mtip held", 32'(mtip), 32'h1);
    end
    bus_access(mtimecmp_hi, 32'hFFFF_FFFF, 4'hF, rdata, resp_error);
    bus_access(mtimecmp_lo, 32'hFFFF_FFFF, 4'hF, rdata, resp_error);
    check_value("mtip after clear", 32'(mtip), 32'h0);
    bus_access(mtimecmp_hi, 32'h0, 4'h0, rdata, resp_error);
    check_value("mtimecmp high readback", rdata, 32'hFFFF_FFFF);
  endtask

  // ======================================================================
  // main sequence and watchdog
  // ======================================================================

  initial begin
    reset = 1'b0;
    mem_valid = 1'b0;
    mem_addr = 32'h0;
    mem_wdata = 32'h0;
    mem_wstrb = 4'h0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b1;
    check_value("mem_ready after reset", 32'(mem_ready), 32'h0);
    check_value("mem_error after reset", 32'(mem_error), 32'h0);
    check_value("msip after reset", 32'(msip), 32'h0);
    check_value("mtip after reset", 32'(mtip), 32'h0);
    check_value("tx after reset", 32'(tx), 32'h1);
    ram_test();
    unmapped_test();
    for (int i = 0; i < uart_frames; i++) begin
      uart_test(8'(next_bits(8)), 8'(next_bits(8)));
    end
    clint_test();
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    abort_run($sformatf("watchdog expired after %0d cycles, the run hung", watchdog_cycles));
  end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/soc_pkg.sv
hdl/bus_decoder.sv
hdl/ram.sv
hdl/clint.sv
hdl/uart_tx.sv
hdl/soc_bus.sv
verification/soc_bus_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module soc_bus_tb \
  -f filelist.f -Mdir obj_dir -o soc_bus_sim

./obj_dir/soc_bus_sim
